// File: design/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address and data word widths
`define CACHE_ADDR_W   32
`define CACHE_DATA_W   32

// One word per line, so the offset only selects a byte
`define CACHE_OFFSET_W 2

// Sets per way
`define CACHE_SETS     16
`define CACHE_INDEX_W  4

// Tag is whatever is left above index and offset
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

// File: design/cache_geom_pkg.sv
`include "cache_defines.svh"

package cache_geom_pkg;

    // ----------------------------------------------------------------------
    // Address geometry
    // ----------------------------------------------------------------------
    typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`CACHE_DATA_W-1:0]  word_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;

    // Two ways, so a single bit
    typedef logic way_t;

    // Set lookup result, one cycle behind the bank read
    typedef struct packed {
        logic hit;
        way_t hit_way;
        logic victim_dirty;
    } lookup_t;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FETCH_REQ,
        ST_FETCH_RSP,
        ST_FILL,
        ST_RESPOND
    } ctrl_state_t;

endpackage

// File: design/cache_axil_pkg.sv
`include "cache_defines.svh"

package cache_axil_pkg;

    // ----------------------------------------------------------------------
    // Processor side, cache is the subordinate
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] awaddr;
        logic                     awvalid;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     wvalid;
        logic [`CACHE_ADDR_W-1:0] araddr;
        logic                     arvalid;
        logic                     bready;
        logic                     rready;
    } sbd_req_t;

    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic                     arready;
        logic                     bvalid;
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     rvalid;
    } sbd_rsp_t;

    // ----------------------------------------------------------------------
    // Memory side, cache is the manager
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] awaddr;
        logic                     awvalid;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     wvalid;
        logic [`CACHE_ADDR_W-1:0] araddr;
        logic                     arvalid;
        logic                     bready;
        logic                     rready;
    } mng_req_t;

    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic                     arready;
        logic                     bvalid;
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     rvalid;
    } mng_rsp_t;

endpackage

// File: design/cache_sram.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_sram
    import cache_geom_pkg::*;
#(
    parameter int DEPTH = `CACHE_SETS,
    parameter int WIDTH = `CACHE_DATA_W
) (
    input  logic             clk,
    input  logic             rst_n,
    input  index_t           addr,
    input  logic             re,
    input  logic             we,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Sync read and write, dout holds while re is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // All entries cleared so metadata starts invalid and clean
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                mem[addr] <= din;
            end
            if (re) begin
                dout <= mem[addr];
            end
        end
    end

    // Single port, callers must never read and write together
    a_one_port: assert property (@(posedge clk) disable iff (!rst_n) !(re && we));

endmodule

// File: design/cache_tag_store.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_tag_store
    import cache_geom_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  index_t  index,
    input  logic    re,
    input  tag_t    lookup_tag,
    input  logic    touch,
    input  logic    fill,
    input  logic    fill_dirty,
    output lookup_t result,
    output way_t    victim_way,
    output tag_t    victim_tag
);

    tag_t tag_q   [2];
    logic valid_q [2];
    logic dirty_q [2];
    logic hit_w   [2];
    logic lru_q;
    logic lru_we;

    // ----------------------------------------------------------------------
    // Per-way tag, valid and dirty banks
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < 2; w++) begin : g_way
        logic meta_we;
        logic dirty_we;

        // Fill rewrites the victim's metadata
        assign meta_we  = fill && (victim_way == way_t'(w));
        // Write hit marks the hit way dirty
        assign dirty_we = meta_we || (touch && fill_dirty && (result.hit_way == way_t'(w)));

        cache_sram #(.DEPTH(`CACHE_SETS), .WIDTH(`CACHE_TAG_W)) i_tag (
            .clk  (clk),
            .rst_n(rst_n),
            .addr (index),
            .re   (re && !meta_we),
            .we   (meta_we),
            .din  (lookup_tag),
            .dout (tag_q[w])
        );

        cache_sram #(.DEPTH(`CACHE_SETS), .WIDTH(1)) i_valid (
            .clk  (clk),
            .rst_n(rst_n),
            .addr (index),
            .re   (re && !meta_we),
            .we   (meta_we),
            .din  (1'b1),
            .dout (valid_q[w])
        );

        cache_sram #(.DEPTH(`CACHE_SETS), .WIDTH(1)) i_dirty (
            .clk  (clk),
            .rst_n(rst_n),
            .addr (index),
            .re   (re && !dirty_we),
            .we   (dirty_we),
            .din  (fill_dirty),
            .dout (dirty_q[w])
        );

        // Tag match on a valid line
        assign hit_w[w] = valid_q[w] && (tag_q[w] == lookup_tag);
    end

    // ----------------------------------------------------------------------
    // LRU bit per set, value is the way to evict next
    // ----------------------------------------------------------------------
    assign lru_we = touch || fill;

    cache_sram #(.DEPTH(`CACHE_SETS), .WIDTH(1)) i_lru (
        .clk  (clk),
        .rst_n(rst_n),
        .addr (index),
        .re   (re && !lru_we),
        .we   (lru_we),
        .din  (fill ? ~victim_way : ~result.hit_way),
        .dout (lru_q)
    );

    assign victim_way = lru_q;
    // Victim tag forms the write-back address
    assign victim_tag = tag_q[victim_way];

    always_comb begin
        result.hit          = hit_w[0] || hit_w[1];
        result.hit_way      = hit_w[1];
        result.victim_dirty = dirty_q[victim_way];
    end

    // Controller strobes one metadata update at a time
    a_touch_fill: assert property (@(posedge clk) disable iff (!rst_n) !(touch && fill));

endmodule

// File: design/cache_data_store.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_data_store
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,
    input  logic   re,
    input  logic   we,
    input  way_t   way,
    input  word_t  din,
    output word_t  dout0,
    output word_t  dout1
);

    word_t dout_q [2];

    // One bank per way, both read in parallel
    for (genvar w = 0; w < 2; w++) begin : g_bank
        logic bank_we;

        // Only the selected way is written
        assign bank_we = we && (way == way_t'(w));

        cache_sram #(.DEPTH(`CACHE_SETS), .WIDTH(`CACHE_DATA_W)) i_data (
            .clk  (clk),
            .rst_n(rst_n),
            .addr (index),
            .re   (re && !bank_we),
            .we   (bank_we),
            .din  (din),
            .dout (dout_q[w])
        );
    end

    assign dout0 = dout_q[0];
    assign dout1 = dout_q[1];

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_axil_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  sbd_req_t sbd_req,
    output sbd_rsp_t sbd_rsp,
    output mng_req_t mng_req,
    input  mng_rsp_t mng_rsp,
    output index_t   ram_index,
    output logic     ram_re,
    output tag_t     req_tag,
    input  lookup_t  result,
    input  way_t     victim_way,
    input  tag_t     victim_tag,
    output logic     touch,
    output logic     fill,
    output logic     fill_dirty,
    output logic     data_we,
    output way_t     data_way,
    output word_t    data_din,
    input  word_t    dout0,
    input  word_t    dout1
);

    localparam int IDX_LO = `CACHE_OFFSET_W;
    localparam int TAG_LO = `CACHE_OFFSET_W + `CACHE_INDEX_W;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        is_write;
    index_t      req_index;
    word_t       wdata_q;
    word_t       fetched_q;
    logic        aw_done;
    logic        w_done;
    logic        wb_done;
    addr_t       in_addr;
    logic        rd_accept;
    logic        wr_accept;
    logic        hit_ack;
    word_t       hit_data;
    word_t       victim_data;

    // ----------------------------------------------------------------------
    // Request acceptance with reads ahead of writes
    // ----------------------------------------------------------------------
    assign in_addr   = sbd_req.arvalid ? sbd_req.araddr : sbd_req.awaddr;
    assign rd_accept = (state == ST_IDLE) && sbd_req.arvalid;
    assign wr_accept = (state == ST_IDLE) && !sbd_req.arvalid
                       && sbd_req.awvalid && sbd_req.wvalid;

    // Hit answered and taken by the processor
    assign hit_ack = (state == ST_LOOKUP) && result.hit
                     && (is_write ? sbd_req.bready : sbd_req.rready);
    assign wb_done = mng_req.bready && mng_rsp.bvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state   <= state_nxt;
            // AW and W may complete in either order
            aw_done <= (state == ST_WRITEBACK) && !wb_done
                       && (aw_done || (mng_req.awvalid && mng_rsp.awready));
            w_done  <= (state == ST_WRITEBACK) && !wb_done
                       && (w_done || (mng_req.wvalid && mng_rsp.wready));
        end
    end

    // Request and fetched word
    always_ff @(posedge clk) begin
        if (rd_accept || wr_accept) begin
            is_write  <= wr_accept;
            req_tag   <= in_addr[`CACHE_ADDR_W-1:TAG_LO];
            req_index <= in_addr[TAG_LO-1:IDX_LO];
            wdata_q   <= sbd_req.wdata;
        end
        if (mng_req.rready && mng_rsp.rvalid) begin
            fetched_q <= mng_rsp.rdata;
        end
    end

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (rd_accept || wr_accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (result.hit) begin
                    if (hit_ack) begin
                        state_nxt = ST_IDLE;
                    end
                end else if (result.victim_dirty) begin
                    state_nxt = ST_WRITEBACK;
                end else begin
                    // Write miss needs no fetch since the word is the whole line
                    state_nxt = is_write ? ST_FILL : ST_FETCH_REQ;
                end
            end
            ST_WRITEBACK: begin
                if (wb_done) begin
                    state_nxt = is_write ? ST_FILL : ST_FETCH_REQ;
                end
            end
            ST_FETCH_REQ: begin
                if (mng_rsp.arready) begin
                    state_nxt = ST_FETCH_RSP;
                end
            end
            ST_FETCH_RSP: begin
                if (mng_rsp.rvalid) begin
                    state_nxt = ST_FILL;
                end
            end
            ST_FILL: begin
                state_nxt = ST_RESPOND;
            end
            ST_RESPOND: begin
                if (is_write ? sbd_req.bready : sbd_req.rready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Store control
    // ----------------------------------------------------------------------
    // Incoming index in idle and the registered index after
    assign ram_index = (state == ST_IDLE) ? in_addr[TAG_LO-1:IDX_LO] : req_index;
    // Lookup keeps re-reading so the hit output holds under back-pressure
    assign ram_re     = (state == ST_IDLE) || (state == ST_LOOKUP);
    assign touch      = hit_ack;
    assign fill       = (state == ST_FILL);
    assign fill_dirty = is_write;
    assign data_we    = (hit_ack && is_write) || fill;
    assign data_way   = (state == ST_LOOKUP) ? result.hit_way : victim_way;
    assign data_din   = is_write ? wdata_q : fetched_q;

    assign hit_data    = result.hit_way ? dout1 : dout0;
    // Banks hold the victim word through the write-back
    assign victim_data = victim_way ? dout1 : dout0;

    // ----------------------------------------------------------------------
    // Port outputs
    // ----------------------------------------------------------------------
    always_comb begin
        sbd_rsp.arready = (state == ST_IDLE);
        sbd_rsp.awready = (state == ST_IDLE);
        sbd_rsp.wready  = (state == ST_IDLE);
        sbd_rsp.rvalid  = !is_write && (((state == ST_LOOKUP) && result.hit)
                                        || (state == ST_RESPOND));
        sbd_rsp.bvalid  = is_write && (((state == ST_LOOKUP) && result.hit)
                                       || (state == ST_RESPOND));
        sbd_rsp.rdata   = (state == ST_RESPOND) ? fetched_q : hit_data;

        // Line-aligned manager addresses
        mng_req.awaddr  = {victim_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
        mng_req.awvalid = (state == ST_WRITEBACK) && !aw_done;
        mng_req.wdata   = victim_data;
        mng_req.wvalid  = (state == ST_WRITEBACK) && !w_done;
        mng_req.bready  = (state == ST_WRITEBACK) && aw_done && w_done;
        mng_req.araddr  = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
        mng_req.arvalid = (state == ST_FETCH_REQ);
        mng_req.rready  = (state == ST_FETCH_RSP);
    end

    // Read data held across the bank re-reads until taken
    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sbd_rsp.rvalid && !sbd_req.rready |=> sbd_rsp.rvalid && $stable(sbd_rsp.rdata));

    // Fetch valid and address stay up until memory takes them
    a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mng_req.arvalid && !mng_rsp.arready |=> mng_req.arvalid && $stable(mng_req.araddr));

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_geom_pkg::*;
    import cache_axil_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  sbd_req_t sbd_req,
    output sbd_rsp_t sbd_rsp,
    output mng_req_t mng_req,
    input  mng_rsp_t mng_rsp
);

    // Controller to stores
    index_t  ram_index;
    logic    ram_re;
    tag_t    req_tag;
    lookup_t result;
    way_t    victim_way;
    tag_t    victim_tag;
    logic    touch;
    logic    fill;
    logic    fill_dirty;
    logic    data_we;
    way_t    data_way;
    word_t   data_din;
    word_t   dout0;
    word_t   dout1;

    cache_ctrl i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .sbd_req   (sbd_req),
        .sbd_rsp   (sbd_rsp),
        .mng_req   (mng_req),
        .mng_rsp   (mng_rsp),
        .ram_index (ram_index),
        .ram_re    (ram_re),
        .req_tag   (req_tag),
        .result    (result),
        .victim_way(victim_way),
        .victim_tag(victim_tag),
        .touch     (touch),
        .fill      (fill),
        .fill_dirty(fill_dirty),
        .data_we   (data_we),
        .data_way  (data_way),
        .data_din  (data_din),
        .dout0     (dout0),
        .dout1     (dout1)
    );

    // Metadata and replacement
    cache_tag_store i_tag_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (ram_index),
        .re        (ram_re),
        .lookup_tag(req_tag),
        .touch     (touch),
        .fill      (fill),
        .fill_dirty(fill_dirty),
        .result    (result),
        .victim_way(victim_way),
        .victim_tag(victim_tag)
    );

    // Line data for both ways
    cache_data_store i_data_store (
        .clk  (clk),
        .rst_n(rst_n),
        .index(ram_index),
        .re   (ram_re),
        .we   (data_we),
        .way  (data_way),
        .din  (data_din),
        .dout0(dout0),
        .dout1(dout1)
    );

endmodule

// File: verif/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model
    import cache_geom_pkg::*;
    import cache_axil_pkg::*;
#(
    parameter word_t PATTERN = 32'h5a3c_96e1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mng_req_t mng_req,
    output mng_rsp_t mng_rsp,
    output int       rd_count,
    output int       wr_count,
    output addr_t    last_rd_addr,
    output addr_t    last_wr_addr,
    output word_t    last_wr_data
);

    logic  wr_ready;
    logic  ar_ready;
    logic  b_valid;
    logic  r_valid;
    word_t r_data;
    // Accepted writes in arrival order
    addr_t wr_addr_q [$];
    word_t wr_data_q [$];

    // Untouched words read back as address XOR pattern
    function automatic word_t stored_word(input addr_t addr);
        word_t val;
        val = addr ^ PATTERN;
        foreach (wr_addr_q[i]) begin
            if (wr_addr_q[i] == addr) begin
                val = wr_data_q[i];
            end
        end
        return val;
    endfunction

    // Idle for 0 to 3 cycles between two points 1 ns after an edge
    task automatic random_gap();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    always_comb begin
        mng_rsp.awready = wr_ready;
        mng_rsp.wready  = wr_ready;
        mng_rsp.arready = ar_ready;
        mng_rsp.bvalid  = b_valid;
        mng_rsp.rdata   = r_data;
        mng_rsp.rvalid  = r_valid;
    end

    initial begin
        wr_ready     = 1'b0;
        ar_ready     = 1'b0;
        b_valid      = 1'b0;
        r_valid      = 1'b0;
        r_data       = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
    end

    // ----------------------------------------------------------------------
    // Write channels with AW and W taken on the same edge
    // ----------------------------------------------------------------------
    always begin
        @(posedge clk);
        if (rst_n && mng_req.awvalid && mng_req.wvalid) begin
            #1;
            random_gap();
            wr_ready = 1'b1;
            // Handshake only on an edge with both valids still up
            do @(posedge clk); while (!(mng_req.awvalid && mng_req.wvalid));
            wr_addr_q.push_back(mng_req.awaddr);
            wr_data_q.push_back(mng_req.wdata);
            last_wr_addr = mng_req.awaddr;
            last_wr_data = mng_req.wdata;
            wr_count++;
            #1;
            wr_ready = 1'b0;
            random_gap();
            // Response held until the cache takes it
            b_valid = 1'b1;
            do @(posedge clk); while (!mng_req.bready);
            #1;
            b_valid = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Read channels
    // ----------------------------------------------------------------------
    always begin
        @(posedge clk);
        if (rst_n && mng_req.arvalid) begin
            #1;
            random_gap();
            ar_ready = 1'b1;
            // Address taken only while arvalid is still up
            do @(posedge clk); while (!mng_req.arvalid);
            last_rd_addr = mng_req.araddr;
            rd_count++;
            #1;
            ar_ready = 1'b0;
            random_gap();
            r_data  = stored_word(last_rd_addr);
            r_valid = 1'b1;
            do @(posedge clk); while (!mng_req.rready);
            #1;
            r_valid = 1'b0;
        end
    end

endmodule

// File: verif/cache_tb.sv
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_tb
    import cache_geom_pkg::*;
    import cache_axil_pkg::*;
();

    localparam int    CLK_PERIOD  = 8;
    localparam int    NUM_TXNS    = 20;
    localparam word_t MEM_PATTERN = 32'h5a3c_96e1;

    // A and B in their own sets, X1 to X3 all in set 9
    localparam addr_t ADDR_A  = {tag_t'('h100), index_t'(3), {`CACHE_OFFSET_W{1'b0}}};
    localparam addr_t ADDR_B  = {tag_t'('h200), index_t'(5), {`CACHE_OFFSET_W{1'b0}}};
    localparam addr_t ADDR_X1 = {tag_t'('h311), index_t'(9), {`CACHE_OFFSET_W{1'b0}}};
    localparam addr_t ADDR_X2 = {tag_t'('h322), index_t'(9), {`CACHE_OFFSET_W{1'b0}}};
    localparam addr_t ADDR_X3 = {tag_t'('h333), index_t'(9), {`CACHE_OFFSET_W{1'b0}}};

    localparam word_t DATA_1 = 32'hcafe_0001;
    localparam word_t DATA_2 = 32'hbeef_0002;
    localparam word_t DATA_3 = 32'hd00d_0003;
    localparam word_t DATA_4 = 32'hf00d_0004;

    logic     clk;
    logic     rst_n;
    sbd_req_t sbd_req;
    sbd_rsp_t sbd_rsp;
    mng_req_t mng_req;
    mng_rsp_t mng_rsp;
    int       rd_count;
    int       wr_count;
    addr_t    last_rd_addr;
    addr_t    last_wr_addr;
    word_t    last_wr_data;
    int       errors;
    int       tests_run;
    int       tests_failed;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top i_cache_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .sbd_req(sbd_req),
        .sbd_rsp(sbd_rsp),
        .mng_req(mng_req),
        .mng_rsp(mng_rsp)
    );

    axil_mem_model #(.PATTERN(MEM_PATTERN)) i_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mng_req     (mng_req),
        .mng_rsp     (mng_rsp),
        .rd_count    (rd_count),
        .wr_count    (wr_count),
        .last_rd_addr(last_rd_addr),
        .last_wr_addr(last_wr_addr),
        .last_wr_data(last_wr_data)
    );

    // Backing store contents before any write
    function automatic word_t mem_default(input addr_t addr);
        return addr ^ MEM_PATTERN;
    endfunction

    // ----------------------------------------------------------------------
    // Processor-side transactions, all start and end 1 ns after an edge
    // ----------------------------------------------------------------------
    task automatic read_line(input addr_t addr, input int stall,
                             output word_t data, output int lat);
        lat = 0;
        sbd_req.araddr  = addr;
        sbd_req.arvalid = 1'b1;
        // Accepting edge, arready only high in idle
        do @(posedge clk); while (!sbd_rsp.arready);
        #1;
        sbd_req.arvalid = 1'b0;
        // Edges after acceptance until rvalid
        do begin
            @(posedge clk);
            lat++;
        end while (!sbd_rsp.rvalid);
        data = sbd_rsp.rdata;
        // rready low for the stall, response must not move
        for (int i = 0; i <= stall; i++) begin
            #1;
            sbd_req.rready = (i == stall);
            @(posedge clk);
            if (sbd_rsp.rvalid !== 1'b1 || sbd_rsp.rdata !== data) begin
                $display("mismatch at %0t: read response for %h changed before rready",
                         $time, addr);
                errors++;
            end
        end
        #1;
        sbd_req.rready = 1'b0;
    endtask

    task automatic write_line(input addr_t addr, input word_t data, input int stall);
        sbd_req.awaddr  = addr;
        sbd_req.awvalid = 1'b1;
        sbd_req.wdata   = data;
        sbd_req.wvalid  = 1'b1;
        do @(posedge clk); while (!sbd_rsp.awready);
        #1;
        sbd_req.awvalid = 1'b0;
        sbd_req.wvalid  = 1'b0;
        do @(posedge clk); while (!sbd_rsp.bvalid);
        for (int i = 0; i <= stall; i++) begin
            #1;
            sbd_req.bready = (i == stall);
            @(posedge clk);
            if (sbd_rsp.bvalid !== 1'b1) begin
                $display("bvalid dropped before bready for the write to %h", addr);
                errors++;
            end
        end
        #1;
        sbd_req.bready = 1'b0;
    endtask

    // Read with expected data, manager traffic and optional latency
    task automatic verify_read(input addr_t addr, input word_t exp, input int exp_rd,
                               input int exp_wr, input int stall, input int exp_lat);
        int    rd0;
        int    wr0;
        int    lat;
        word_t got;
        rd0 = rd_count;
        wr0 = wr_count;
        read_line(addr, stall, got, lat);
        if (got !== exp) begin
            $display("mismatch at %0t: read %h returned %h, expected %h", $time, addr, got, exp);
            errors++;
        end
        if (rd_count - rd0 != exp_rd || wr_count - wr0 != exp_wr) begin
            $display("mismatch at %0t: read %h made %0d/%0d manager reads/writes, expected %0d/%0d",
                     $time, addr, rd_count - rd0, wr_count - wr0, exp_rd, exp_wr);
            errors++;
        end
        if (exp_lat != 0 && lat != exp_lat) begin
            $display("mismatch at %0t: read %h latency %0d, expected %0d", $time, addr, lat, exp_lat);
            errors++;
        end
    endtask

    task automatic verify_write(input addr_t addr, input word_t data, input int exp_rd,
                                input int exp_wr, input int stall);
        int rd0;
        int wr0;
        rd0 = rd_count;
        wr0 = wr_count;
        write_line(addr, data, stall);
        if (rd_count - rd0 != exp_rd || wr_count - wr0 != exp_wr) begin
            $display("mismatch at %0t: write %h made %0d/%0d manager reads/writes, expected %0d/%0d",
                     $time, addr, rd_count - rd0, wr_count - wr0, exp_rd, exp_wr);
            errors++;
        end
    endtask

    task automatic log_result(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic reset_values();
        int err0;
        err0 = errors;
        if (sbd_rsp.rvalid !== 1'b0 || sbd_rsp.bvalid !== 1'b0
            || sbd_rsp.arready !== 1'b1 || sbd_rsp.awready !== 1'b1
            || sbd_rsp.wready !== 1'b1) begin
            $display("mismatch at %0t: processor side not idle after reset", $time);
            errors++;
        end
        if (mng_req.awvalid !== 1'b0 || mng_req.wvalid !== 1'b0 || mng_req.arvalid !== 1'b0
            || mng_req.bready !== 1'b0 || mng_req.rready !== 1'b0) begin
            $display("mismatch at %0t: memory side not quiet after reset", $time);
            errors++;
        end
        log_result("reset values", err0);
    endtask

    task automatic cold_read();
        int err0;
        err0 = errors;
        // Byte offset set, fetch still line-aligned
        verify_read(ADDR_A | addr_t'(1), mem_default(ADDR_A), 1, 0, 0, 0);
        if (last_rd_addr !== ADDR_A) begin
            $display("mismatch at %0t: fetch address %h, expected %h", $time, last_rd_addr, ADDR_A);
            errors++;
        end
        log_result("cold read miss", err0);
    endtask

    task automatic repeat_read();
        int err0;
        err0 = errors;
        verify_read(ADDR_A, mem_default(ADDR_A), 0, 0, 0, 1);
        log_result("read hit", err0);
    endtask

    task automatic write_hit();
        int err0;
        err0 = errors;
        verify_write(ADDR_A, DATA_1, 0, 0, 0);
        verify_read(ADDR_A, DATA_1, 0, 0, 0, 0);
        log_result("write hit", err0);
    endtask

    task automatic write_allocate();
        int err0;
        err0 = errors;
        // Clean empty set, no fetch and no write-back
        verify_write(ADDR_B, DATA_2, 0, 0, 0);
        verify_read(ADDR_B, DATA_2, 0, 0, 0, 0);
        log_result("write miss allocate", err0);
    endtask

    task automatic eviction();
        int err0;
        err0 = errors;
        // X1 into way 0, then X2 allocated dirty in way 1
        verify_read(ADDR_X1, mem_default(ADDR_X1), 1, 0, 0, 0);
        verify_write(ADDR_X2, DATA_3, 0, 0, 0);
        // Touch X1 so dirty X2 is LRU
        verify_read(ADDR_X1, mem_default(ADDR_X1), 0, 0, 0, 0);
        // X3 evicts X2, one write-back then a fetch
        verify_read(ADDR_X3, mem_default(ADDR_X3), 1, 1, 0, 0);
        if (last_wr_addr !== ADDR_X2 || last_wr_data !== DATA_3) begin
            $display("mismatch at %0t: write-back %h data %h, expected %h data %h",
                     $time, last_wr_addr, last_wr_data, ADDR_X2, DATA_3);
            errors++;
        end
        // X1 survived the eviction
        verify_read(ADDR_X1, mem_default(ADDR_X1), 0, 0, 0, 0);
        // Clean X3 now LRU, X2 comes back from memory
        verify_read(ADDR_X2, DATA_3, 1, 0, 0, 0);
        verify_read(ADDR_X1, mem_default(ADDR_X1), 0, 0, 0, 0);
        log_result("eviction", err0);
    endtask

    task automatic stalled_reads();
        int err0;
        err0 = errors;
        verify_read(ADDR_A, DATA_1, 0, 0, $urandom_range(4, 1), 0);
        verify_read(ADDR_B, DATA_2, 0, 0, $urandom_range(4, 1), 0);
        verify_read(ADDR_X2, DATA_3, 0, 0, $urandom_range(4, 1), 0);
        // Clean victims on both misses
        verify_read(ADDR_X3, mem_default(ADDR_X3), 1, 0, $urandom_range(4, 1), 0);
        verify_read(ADDR_X1, mem_default(ADDR_X1), 1, 0, $urandom_range(4, 1), 0);
        verify_write(ADDR_A, DATA_4, 0, 0, $urandom_range(4, 1));
        verify_read(ADDR_A, DATA_4, 0, 0, $urandom_range(4, 1), 0);
        log_result("back-pressure", err0);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(62));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        sbd_req      = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        cold_read();
        repeat_read();
        write_hit();
        write_allocate();
        eviction();
        stalled_reads();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Generous budget per transaction
    initial begin
        #(NUM_TXNS * 80 * CLK_PERIOD);
        $display("timeout: the cache stopped responding before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/cache_geom_pkg.sv
design/cache_axil_pkg.sv
design/cache_sram.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
verif/axil_mem_model.sv
verif/cache_tb.sv

// File: Bender.yml
package:
  name: cache_axil

sources:
  - include_dirs:
      - design
    files:
      - design/cache_geom_pkg.sv
      - design/cache_axil_pkg.sv
      - design/cache_sram.sv
      - design/cache_tag_store.sv
      - design/cache_data_store.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/axil_mem_model.sv
      - verif/cache_tb.sv
